// ==== filelist.f ====
gpr_pkg.sv
gpr_write_if.sv
gpr_write_select.sv
gpr_array.sv
gpr_read_port.sv
gpr_regfile_top.sv
tb_clock_gen.sv
gpr_regfile_tb.sv

// ==== gpr_regfile_tb.sv ====
//------------------------------
// register file testbench with reference model,
// directed and random stimulus, read-port assertions
//------------------------------
module gpr_regfile_tb import gpr_pkg::*; ();

    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES   = 200;
    localparam int CYCLE_LIMIT     = DIRECTED_CYCLES + RANDOM_CYCLES + 140;

    logic      clk;
    logic      rst_n;

    gpr_addr_t wb0_addr;
    gpr_data_t wb0_data;
    gpr_addr_t wb1_addr;
    gpr_data_t wb1_data;
    gpr_addr_t dbg_waddr;
    gpr_data_t dbg_wdata;

    gpr_addr_t ra0_addr;
    gpr_addr_t rb0_addr;
    gpr_addr_t ra1_addr;
    gpr_addr_t rb1_addr;
    gpr_addr_t dbg_raddr;

    gpr_data_t ra0_data;
    gpr_data_t rb0_data;
    gpr_data_t ra1_data;
    gpr_data_t rb1_data;
    gpr_data_t dbg_rdata;

    // reference model, x0 never written
    gpr_data_t model [GPR_COUNT];
    gpr_data_t exp_ra0;
    gpr_data_t exp_rb0;
    gpr_data_t exp_ra1;
    gpr_data_t exp_rb1;
    gpr_data_t exp_dbg;

    integer    seed;
    int        errors;
    int        checks;
    int        cycles;

    tb_clock_gen clock_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    gpr_regfile_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb0_addr_i  (wb0_addr),
        .wb0_data_i  (wb0_data),
        .wb1_addr_i  (wb1_addr),
        .wb1_data_i  (wb1_data),
        .dbg_waddr_i (dbg_waddr),
        .dbg_wdata_i (dbg_wdata),
        .ra0_addr_i  (ra0_addr),
        .rb0_addr_i  (rb0_addr),
        .ra1_addr_i  (ra1_addr),
        .rb1_addr_i  (rb1_addr),
        .dbg_raddr_i (dbg_raddr),
        .ra0_data_o  (ra0_data),
        .rb0_data_o  (rb0_data),
        .ra1_data_o  (ra1_data),
        .rb1_data_o  (rb1_data),
        .dbg_rdata_o (dbg_rdata)
    );

    //------------------------------
    // reference model
    //------------------------------
    // lowest priority first, so the highest writer lands last
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                model[i] <= GPR_RESET_VALUE;
            end
        end else begin
            if (dbg_waddr != GPR_ZERO_ADDR) begin
                model[dbg_waddr] <= dbg_wdata;
            end
            if (wb1_addr != GPR_ZERO_ADDR) begin
                model[wb1_addr] <= wb1_data;
            end
            if (wb0_addr != GPR_ZERO_ADDR) begin
                model[wb0_addr] <= wb0_data;
            end
        end
    end

    assign exp_ra0 = model[ra0_addr];
    assign exp_rb0 = model[rb0_addr];
    assign exp_ra1 = model[ra1_addr];
    assign exp_rb1 = model[rb1_addr];
    assign exp_dbg = model[dbg_raddr];

    //------------------------------
    // read port assertions
    //------------------------------
    task automatic report_mismatch(input string name, input gpr_data_t exp,
                                   input gpr_data_t act);
        errors++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    ra0_check: assert property (@(posedge clk) disable iff (!rst_n) ra0_data == exp_ra0)
        else report_mismatch("ra0_data_o", $sampled(exp_ra0), $sampled(ra0_data));
    rb0_check: assert property (@(posedge clk) disable iff (!rst_n) rb0_data == exp_rb0)
        else report_mismatch("rb0_data_o", $sampled(exp_rb0), $sampled(rb0_data));
    ra1_check: assert property (@(posedge clk) disable iff (!rst_n) ra1_data == exp_ra1)
        else report_mismatch("ra1_data_o", $sampled(exp_ra1), $sampled(ra1_data));
    rb1_check: assert property (@(posedge clk) disable iff (!rst_n) rb1_data == exp_rb1)
        else report_mismatch("rb1_data_o", $sampled(exp_rb1), $sampled(rb1_data));
    dbg_check: assert property (@(posedge clk) disable iff (!rst_n) dbg_rdata == exp_dbg)
        else report_mismatch("dbg_rdata_o", $sampled(exp_dbg), $sampled(dbg_rdata));

    // five ports compared on every edge out of reset
    always @(posedge clk) begin
        if (rst_n) begin
            checks <= checks + 5;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped: no end of stimulus after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    //------------------------------
    // stimulus helpers
    //------------------------------
    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic drive_writes(input gpr_addr_t a0, input gpr_data_t d0,
                                input gpr_addr_t a1, input gpr_data_t d1,
                                input gpr_addr_t ad, input gpr_data_t dd);
        wb0_addr  = a0;
        wb0_data  = d0;
        wb1_addr  = a1;
        wb1_data  = d1;
        dbg_waddr = ad;
        dbg_wdata = dd;
    endtask

    task automatic clear_writes();
        drive_writes('0, '0, '0, '0, '0, '0);
    endtask

    task automatic drive_reads(input gpr_addr_t a0, input gpr_addr_t b0,
                               input gpr_addr_t a1, input gpr_addr_t b1,
                               input gpr_addr_t d);
        ra0_addr  = a0;
        rb0_addr  = b0;
        ra1_addr  = a1;
        rb1_addr  = b1;
        dbg_raddr = d;
    endtask

    // one writer, then the same register on all five ports
    task automatic write_and_read_back(input int which, input gpr_addr_t addr,
                                       input gpr_data_t data);
        next_cycle();
        case (which)
            0: drive_writes(addr, data, '0, '0, '0, '0);
            1: drive_writes('0, '0, addr, data, '0, '0);
            default: drive_writes('0, '0, '0, '0, addr, data);
        endcase
        next_cycle();
        clear_writes();
        drive_reads(addr, addr, addr, addr, addr);
    endtask

    task automatic drive_random();
        gpr_addr_t   a0;
        gpr_addr_t   a1;
        gpr_addr_t   ad;
        gpr_data_t   d0;
        gpr_data_t   d1;
        gpr_data_t   dd;
        logic [31:0] pick;
        a0   = gpr_addr_t'($random(seed));
        a1   = gpr_addr_t'($random(seed));
        ad   = gpr_addr_t'($random(seed));
        d0   = $random(seed);
        d1   = $random(seed);
        dd   = $random(seed);
        pick = $random(seed);
        // push some writers onto the same register
        if (pick[1:0] == 2'd0) a1 = a0;
        if (pick[3:2] == 2'd0) ad = a0;
        if (pick[5:4] == 2'd0) ad = a1;
        drive_writes(a0, d0, a1, d1, ad, dd);
        drive_reads(gpr_addr_t'($random(seed)), gpr_addr_t'($random(seed)),
                    gpr_addr_t'($random(seed)), gpr_addr_t'($random(seed)),
                    gpr_addr_t'($random(seed)));
    endtask

    //------------------------------
    // test sequence
    //------------------------------
    initial begin
        seed   = 32'hd169_4fff;
        errors = 0;
        checks = 0;
        cycles = 0;
        clear_writes();
        drive_reads('0, '0, '0, '0, '0);
        wait (rst_n === 1'b1);

        // every address reads zero after reset
        for (int i = 0; i < GPR_COUNT; i++) begin
            next_cycle();
            drive_reads(gpr_addr_t'(i), gpr_addr_t'(GPR_COUNT - 1 - i),
                        gpr_addr_t'(i + 8), gpr_addr_t'(i + 16), gpr_addr_t'(i + 24));
        end

        // single writes from each writer
        write_and_read_back(0, 5'd3, 32'h0bad_f00d);
        write_and_read_back(1, 5'd17, 32'h1234_5678);
        write_and_read_back(2, 5'd31, 32'hcafe_0001);

        // collisions on one register
        next_cycle();
        drive_writes(5'd5, 32'h1111_0000, 5'd5, 32'h2222_0000, 5'd5, 32'h3333_0000);
        next_cycle();
        drive_writes(5'd6, 32'h1111_0006, 5'd7, 32'h2222_0007, 5'd6, 32'h3333_0006);
        drive_reads(5'd5, 5'd5, 5'd5, 5'd5, 5'd5);
        next_cycle();
        drive_writes(5'd8, 32'h1111_0008, 5'd8, 32'h2222_0008, '0, '0);
        drive_reads(5'd6, 5'd7, 5'd6, 5'd7, 5'd5);
        next_cycle();
        drive_writes('0, '0, 5'd12, 32'h2222_000c, 5'd12, 32'h3333_000c);
        drive_reads(5'd8, 5'd6, 5'd7, 5'd5, 5'd8);
        next_cycle();
        clear_writes();
        drive_reads(5'd12, 5'd8, 5'd12, 5'd6, 5'd12);

        // distinct addresses commit together
        next_cycle();
        drive_writes(5'd9, 32'h9999_0009, 5'd10, 32'haaaa_000a, 5'd11, 32'hbbbb_000b);
        next_cycle();
        clear_writes();
        drive_reads(5'd9, 5'd10, 5'd11, 5'd9, 5'd10);

        // x0 ignores writes, others untouched
        next_cycle();
        drive_writes('0, 32'hdead_beef, '0, 32'hfeed_face, '0, 32'hffff_ffff);
        drive_reads('0, 5'd9, 5'd10, 5'd11, '0);
        next_cycle();
        clear_writes();
        drive_reads('0, '0, 5'd3, 5'd17, '0);
        next_cycle();
        drive_reads(5'd31, 5'd5, 5'd12, '0, 5'd9);

        // random traffic on every writer and reader
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            next_cycle();
            drive_random();
        end

        next_cycle();
        clear_writes();
        next_cycle();
        next_cycle();

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
//------------------------------
// testbench clock and reset source
//------------------------------
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== gpr_regfile_top.sv ====
//------------------------------
// dual-issue integer register file top
// 3 writers, 4 operand reads, 1 debug read
//------------------------------
module gpr_regfile_top import gpr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // write-back slots
    input  gpr_addr_t wb0_addr_i,
    input  gpr_data_t wb0_data_i,
    input  gpr_addr_t wb1_addr_i,
    input  gpr_data_t wb1_data_i,

    // debug write
    input  gpr_addr_t dbg_waddr_i,
    input  gpr_data_t dbg_wdata_i,

    // operand reads for both issue slots
    input  gpr_addr_t ra0_addr_i,
    input  gpr_addr_t rb0_addr_i,
    input  gpr_addr_t ra1_addr_i,
    input  gpr_addr_t rb1_addr_i,

    // debug read
    input  gpr_addr_t dbg_raddr_i,

    output gpr_data_t ra0_data_o,
    output gpr_data_t rb0_data_o,
    output gpr_data_t ra1_data_o,
    output gpr_data_t rb1_data_o,
    output gpr_data_t dbg_rdata_o
);

    logic [GPR_COUNT-1:0] we;
    gpr_src_e             src  [GPR_COUNT];
    gpr_data_t            regs [GPR_COUNT];

    //------------------------------
    // writer bundle
    //------------------------------
    gpr_write_if wr_if ();

    assign wr_if.wb0_addr = wb0_addr_i;
    assign wr_if.wb0_data = wb0_data_i;
    assign wr_if.wb1_addr = wb1_addr_i;
    assign wr_if.wb1_data = wb1_data_i;
    assign wr_if.dbg_addr = dbg_waddr_i;
    assign wr_if.dbg_data = dbg_wdata_i;

    //------------------------------
    // write path
    //------------------------------
    gpr_write_select u_write_select (
        .wr    (wr_if.select),
        .we_o  (we),
        .src_o (src)
    );

    gpr_array u_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wr_if.load),
        .we_i   (we),
        .src_i  (src),
        .regs_o (regs)
    );

    //------------------------------
    // read ports
    //------------------------------
    // issue slot 0
    gpr_read_port u_read_ra0 (
        .addr_i (ra0_addr_i),
        .regs_i (regs),
        .data_o (ra0_data_o)
    );

    gpr_read_port u_read_rb0 (
        .addr_i (rb0_addr_i),
        .regs_i (regs),
        .data_o (rb0_data_o)
    );

    // issue slot 1
    gpr_read_port u_read_ra1 (
        .addr_i (ra1_addr_i),
        .regs_i (regs),
        .data_o (ra1_data_o)
    );

    gpr_read_port u_read_rb1 (
        .addr_i (rb1_addr_i),
        .regs_i (regs),
        .data_o (rb1_data_o)
    );

    gpr_read_port u_read_dbg (
        .addr_i (dbg_raddr_i),
        .regs_i (regs),
        .data_o (dbg_rdata_o)
    );

endmodule

// ==== gpr_read_port.sv ====
//------------------------------
// one combinational read mux
//------------------------------
module gpr_read_port import gpr_pkg::*; (
    input  gpr_addr_t addr_i,
    input  gpr_data_t regs_i [GPR_COUNT],
    output gpr_data_t data_o
);

    // x0 forced to zero regardless of slot contents
    always_comb begin
        if (addr_i == GPR_ZERO_ADDR) begin
            data_o = '0;
        end else begin
            data_o = regs_i[addr_i];
        end
    end

endmodule

// ==== gpr_array.sv ====
//------------------------------
// registers x1..x31 with async reset
//------------------------------
module gpr_array import gpr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    gpr_write_if.load            wr,
    input  logic [GPR_COUNT-1:0] we_i,
    input  gpr_src_e             src_i [GPR_COUNT],
    output gpr_data_t            regs_o [GPR_COUNT]
);

    // x0 has no storage
    assign regs_o[GPR_ZERO_ADDR] = '0;

    //------------------------------
    // storage, one flop word per register
    //------------------------------
    for (genvar i = 1; i < GPR_COUNT; i++) begin : g_reg
        gpr_data_t reg_q;
        gpr_data_t wdata;

        // pick the data of the winning writer
        always_comb begin
            case (src_i[i])
                SRC_WB0: wdata = wr.wb0_data;
                SRC_WB1: wdata = wr.wb1_data;
                SRC_DBG: wdata = wr.dbg_data;
                default: wdata = reg_q;
            endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                reg_q <= GPR_RESET_VALUE;
            end else if (we_i[i]) begin
                reg_q <= wdata;
            end
        end

        assign regs_o[i] = reg_q;
    end

endmodule

// ==== gpr_write_select.sv ====
//------------------------------
// per-register priority decode of the three
// write addresses into enables and source picks
//------------------------------
module gpr_write_select import gpr_pkg::*; (
    gpr_write_if.select       wr,
    output logic [GPR_COUNT-1:0] we_o,
    output gpr_src_e          src_o [GPR_COUNT]
);

    // one-hot address decode per writer
    logic [GPR_COUNT-1:0] hit_wb0;
    logic [GPR_COUNT-1:0] hit_wb1;
    logic [GPR_COUNT-1:0] hit_dbg;

    //------------------------------
    // address decode
    //------------------------------
    always_comb begin
        for (int i = 0; i < GPR_COUNT; i++) begin
            hit_wb0[i] = (wr.wb0_addr == gpr_addr_t'(i));
            hit_wb1[i] = (wr.wb1_addr == gpr_addr_t'(i));
            hit_dbg[i] = (wr.dbg_addr == gpr_addr_t'(i));
        end

        // address zero means no write
        hit_wb0[GPR_ZERO_ADDR] = 1'b0;
        hit_wb1[GPR_ZERO_ADDR] = 1'b0;
        hit_dbg[GPR_ZERO_ADDR] = 1'b0;
    end

    //------------------------------
    // fixed priority wb0 > wb1 > dbg
    //------------------------------
    always_comb begin
        for (int i = 0; i < GPR_COUNT; i++) begin
            if (hit_wb0[i]) begin
                src_o[i] = SRC_WB0;
            end else if (hit_wb1[i]) begin
                src_o[i] = SRC_WB1;
            end else if (hit_dbg[i]) begin
                src_o[i] = SRC_DBG;
            end else begin
                src_o[i] = SRC_NONE;
            end
        end
    end

    // any writer hit loads the register
    assign we_o = hit_wb0 | hit_wb1 | hit_dbg;

endmodule

// ==== gpr_write_if.sv ====
//------------------------------
// write-back and debug writer address/value bundle
//------------------------------
interface gpr_write_if import gpr_pkg::*; ();

    // write-back slot 0, highest priority
    gpr_addr_t wb0_addr;
    gpr_data_t wb0_data;

    // write-back slot 1
    gpr_addr_t wb1_addr;
    gpr_data_t wb1_data;

    // debug port, lowest priority
    gpr_addr_t dbg_addr;
    gpr_data_t dbg_data;

    // address decode side
    modport select (
        input wb0_addr,
        input wb1_addr,
        input dbg_addr
    );

    // data load side
    modport load (
        input wb0_data,
        input wb1_data,
        input dbg_data
    );

endinterface

// ==== gpr_pkg.sv ====
//------------------------------
// register file widths, counts, value types
// and the per-register write source encoding
//------------------------------
package gpr_pkg;

    //------------------------------
    // sizes
    //------------------------------
    localparam int GPR_DATA_W = 32;
    localparam int GPR_ADDR_W = 5;

    // x0 included
    localparam int GPR_COUNT  = 32;

    //------------------------------
    // value types
    //------------------------------
    typedef logic [GPR_DATA_W-1:0] gpr_data_t;
    typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;

    // hardwired zero, also the "no write" address
    localparam gpr_addr_t GPR_ZERO_ADDR   = '0;
    localparam gpr_data_t GPR_RESET_VALUE = '0;

    // which writer loads a register on the next edge
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_WB0  = 2'd1,
        SRC_WB1  = 2'd2,
        SRC_DBG  = 2'd3
    } gpr_src_e;

endpackage
